// ==== source/cpu_pkg.sv ====
// 6502 core shared types
`default_nettype none

package cpu_pkg;

  // --------------------------------------------------
  // Bus widths
  // --------------------------------------------------
  localparam int ADDR_WIDTH = 16;
  localparam int DATA_WIDTH = 8;

  typedef logic [ADDR_WIDTH-1:0] addr_t;
  typedef logic [DATA_WIDTH-1:0] byte_t;

  // Low byte of reset vector, high byte at next address
  localparam addr_t RESET_VECTOR = 16'hFFFC;

  // --------------------------------------------------
  // Supported opcodes
  // --------------------------------------------------
  typedef enum byte_t {
    LDA_IMM = 8'hA9,
    LDA_ABS = 8'hAD,
    LDX_ABS = 8'hAE,
    LDY_ABS = 8'hAC,
    STA_ABS = 8'h8D,
    STX_ABS = 8'h8E,
    STY_ABS = 8'h8C,
    JMP_ABS = 8'h4C,
    ADC_ABS = 8'h6D,
    AND_ABS = 8'h2D,
    ORA_ABS = 8'h0D,
    EOR_ABS = 8'h4D,
    CLC_IMP = 8'h18,
    SEC_IMP = 8'h38,
    NOP_IMP = 8'hEA
  } opcode_e;

  // Sequencer states, all eight codes in use
  typedef enum logic [2:0] {
    RESET,
    VECTOR_1,
    VECTOR_2,
    FETCH,
    DECODE,
    ABS_1,
    ABS_2,
    HALT
  } state_e;

  // Path through the sequencer after DECODE
  typedef enum logic [2:0] {
    MODE_IMPLIED,
    MODE_IMMEDIATE,
    MODE_ABSOLUTE,
    MODE_JUMP,
    MODE_ILLEGAL
  } mode_e;

  // OP_PASS forwards the operand for loads
  typedef enum logic [2:0] {
    OP_ADC,
    OP_AND,
    OP_ORA,
    OP_EOR,
    OP_PASS
  } alu_op_e;

  typedef enum logic [1:0] {
    REG_A,
    REG_X,
    REG_Y
  } reg_sel_e;

  // --------------------------------------------------
  // Decoded instruction
  // --------------------------------------------------
  typedef struct packed {
    mode_e    mode;
    alu_op_e  alu_op;
    reg_sel_e target;       // Load destination or store source
    logic     is_store;
    logic     carry_write;  // Carry takes carry_value
    logic     carry_value;
  } decode_t;

endpackage

`default_nettype wire

// ==== source/exec_if.sv ====
// Sequencer to register file link
`default_nettype none

interface exec_if import cpu_pkg::*; ();

  // Decoded instruction of the current opcode
  decode_t dec;
  // Immediate byte or absolute data byte
  byte_t   operand;
  // One cycle in the last cycle of an instruction
  logic    execute;
  // Register selected by dec.target
  byte_t   store_data;

  modport seq (
    output dec,
    output operand,
    output execute,
    input  store_data
  );

  modport regs (
    input  dec,
    input  operand,
    input  execute,
    output store_data
  );

endinterface

`default_nettype wire

// ==== source/opcode_decoder.sv ====
// Instruction decoder
`default_nettype none

module opcode_decoder import cpu_pkg::*; (
  input  byte_t   ir,
  output decode_t dec
);

  always_comb begin
    // Anything not listed below halts the core
    dec.mode        = MODE_ILLEGAL;
    dec.alu_op      = OP_PASS;
    dec.target      = REG_A;
    dec.is_store    = 1'b0;
    dec.carry_write = 1'b0;
    dec.carry_value = 1'b0;

    case (ir)
      // Implied, only the carry changes
      CLC_IMP: begin
        dec.mode        = MODE_IMPLIED;
        dec.carry_write = 1'b1;
      end
      SEC_IMP: begin
        dec.mode        = MODE_IMPLIED;
        dec.carry_write = 1'b1;
        dec.carry_value = 1'b1;
      end
      NOP_IMP: dec.mode = MODE_IMPLIED;

      LDA_IMM: dec.mode = MODE_IMMEDIATE;

      // Absolute loads through the ALU pass path
      LDA_ABS: dec.mode = MODE_ABSOLUTE;
      LDX_ABS: begin
        dec.mode   = MODE_ABSOLUTE;
        dec.target = REG_X;
      end
      LDY_ABS: begin
        dec.mode   = MODE_ABSOLUTE;
        dec.target = REG_Y;
      end

      // Stores, target is the source register
      STA_ABS: begin
        dec.mode     = MODE_ABSOLUTE;
        dec.is_store = 1'b1;
      end
      STX_ABS: begin
        dec.mode     = MODE_ABSOLUTE;
        dec.target   = REG_X;
        dec.is_store = 1'b1;
      end
      STY_ABS: begin
        dec.mode     = MODE_ABSOLUTE;
        dec.target   = REG_Y;
        dec.is_store = 1'b1;
      end

      JMP_ABS: dec.mode = MODE_JUMP;

      // Accumulator ops with memory
      ADC_ABS: begin
        dec.mode   = MODE_ABSOLUTE;
        dec.alu_op = OP_ADC;
      end
      AND_ABS: begin
        dec.mode   = MODE_ABSOLUTE;
        dec.alu_op = OP_AND;
      end
      ORA_ABS: begin
        dec.mode   = MODE_ABSOLUTE;
        dec.alu_op = OP_ORA;
      end
      EOR_ABS: begin
        dec.mode   = MODE_ABSOLUTE;
        dec.alu_op = OP_EOR;
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// ==== source/alu.sv ====
// Accumulator ALU
`default_nettype none

module alu import cpu_pkg::*; (
  input  byte_t   a,
  input  byte_t   b,
  input  logic    carry_in,
  input  alu_op_e op,
  output byte_t   result,
  output logic    carry_out
);

  // Ninth bit is the carry out of the add
  logic [DATA_WIDTH:0] sum;

  assign sum = {1'b0, a} + {1'b0, b} + {{DATA_WIDTH{1'b0}}, carry_in};

  always_comb begin
    carry_out = 1'b0;
    case (op)
      OP_ADC: begin
        result    = sum[DATA_WIDTH-1:0];
        carry_out = sum[DATA_WIDTH];
      end
      OP_AND:  result = a & b;
      OP_ORA:  result = a | b;
      OP_EOR:  result = a ^ b;
      // Loads
      default: result = b;
    endcase
  end

endmodule

`default_nettype wire

// ==== source/register_file.sv ====
// A, X, Y and carry registers
`default_nettype none

module register_file import cpu_pkg::*; (
  input logic  clk,
  input logic  resetn,
  exec_if.regs exec
);

  byte_t reg_a;
  byte_t reg_x;
  byte_t reg_y;
  logic  carry;

  byte_t alu_result;
  logic  alu_carry;
  logic  write_reg;
  byte_t selected;

  alu i_alu (
    .a         (reg_a),
    .b         (exec.operand),
    .carry_in  (carry),
    .op        (exec.dec.alu_op),
    .result    (alu_result),
    .carry_out (alu_carry)
  );

  // Implied ops leave A, X and Y alone
  assign write_reg = !exec.dec.is_store && (exec.dec.mode != MODE_IMPLIED);

  // --------------------------------------------------
  // Register update on the execute strobe
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (!resetn) begin
      reg_a <= '0;
      reg_x <= '0;
      reg_y <= '0;
      carry <= 1'b0;
    end else if (exec.execute) begin
      if (write_reg) begin
        case (exec.dec.target)
          REG_X:   reg_x <= alu_result;
          REG_Y:   reg_y <= alu_result;
          default: reg_a <= alu_result;
        endcase
        // Only the add produces a carry
        if (exec.dec.alu_op == OP_ADC) begin
          carry <= alu_carry;
        end
      end
      if (exec.dec.carry_write) begin
        carry <= exec.dec.carry_value;
      end
    end
  end

  // Store source for the sequencer
  always_comb begin
    case (exec.dec.target)
      REG_X:   selected = reg_x;
      REG_Y:   selected = reg_y;
      default: selected = reg_a;
    endcase
  end

  assign exec.store_data = selected;

endmodule

`default_nettype wire

// ==== source/bus_sequencer.sv ====
// Bus cycle sequencer
`default_nettype none

module bus_sequencer import cpu_pkg::*; (
  input  logic    clk,
  input  logic    resetn,
  input  byte_t   rd_data,
  input  decode_t dec,
  output byte_t   ir,
  output addr_t   address,
  output byte_t   wr_data,
  output logic    wr_enable,
  exec_if.seq     exec
);

  state_e state;
  addr_t  pc;
  byte_t  operand_lo;
  addr_t  target_addr;
  logic   exec_pulse;

  // High operand byte is on the bus during ABS_1
  assign target_addr = {rd_data, operand_lo};

  // --------------------------------------------------
  // Execute strobe and register file link
  // --------------------------------------------------
  always_comb begin
    case (state)
      DECODE:  exec_pulse = (dec.mode == MODE_IMPLIED) || (dec.mode == MODE_IMMEDIATE);
      ABS_2:   exec_pulse = 1'b1;
      default: exec_pulse = 1'b0;
    endcase
  end

  assign exec.execute = exec_pulse;
  assign exec.dec     = dec;
  // Immediate byte in DECODE, data byte in ABS_2
  assign exec.operand = rd_data;

  // --------------------------------------------------
  // State machine and bus outputs
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (!resetn) begin
      state     <= RESET;
      address   <= RESET_VECTOR;
      wr_enable <= 1'b0;
    end else begin
      case (state)
        RESET: state <= VECTOR_1;

        // Vector low byte on the bus
        VECTOR_1: begin
          pc[7:0] <= rd_data;
          address <= RESET_VECTOR + 16'd1;
          state   <= VECTOR_2;
        end

        // Vector high byte, jump to it
        VECTOR_2: begin
          pc      <= {rd_data, pc[7:0]};
          address <= {rd_data, pc[7:0]};
          state   <= FETCH;
        end

        FETCH: begin
          ir      <= rd_data;
          address <= pc + 16'd1;
          state   <= DECODE;
        end

        // Byte after the opcode is always read
        DECODE: begin
          operand_lo <= rd_data;
          case (dec.mode)
            MODE_IMPLIED: begin
              pc      <= pc + 16'd1;
              address <= pc + 16'd1;
              state   <= FETCH;
            end
            MODE_IMMEDIATE: begin
              pc      <= pc + 16'd2;
              address <= pc + 16'd2;
              state   <= FETCH;
            end
            MODE_ABSOLUTE, MODE_JUMP: begin
              address <= pc + 16'd2;
              state   <= ABS_1;
            end
            // Address holds at opcode plus one
            default: state <= HALT;
          endcase
        end

        ABS_1: begin
          address <= target_addr;
          if (dec.mode == MODE_JUMP) begin
            pc    <= target_addr;
            state <= FETCH;
          end else begin
            // Write strobe covers ABS_2 only
            wr_enable <= dec.is_store;
            wr_data   <= exec.store_data;
            state     <= ABS_2;
          end
        end

        // Data cycle at the operand address
        ABS_2: begin
          wr_enable <= 1'b0;
          pc        <= pc + 16'd3;
          address   <= pc + 16'd3;
          state     <= FETCH;
        end

        // Left only through reset
        default: state <= HALT;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== source/cpu_top.sv ====
// 6502 core top level
`default_nettype none

module cpu_top import cpu_pkg::*; (
  input  logic  clk,
  input  logic  resetn,
  input  byte_t rd_data,
  output addr_t address,
  output byte_t wr_data,
  output logic  wr_enable
);

  byte_t   ir;
  decode_t dec;

  exec_if i_exec_if ();

  // Bus side and control
  bus_sequencer i_bus_sequencer (
    .clk       (clk),
    .resetn    (resetn),
    .rd_data   (rd_data),
    .dec       (dec),
    .ir        (ir),
    .address   (address),
    .wr_data   (wr_data),
    .wr_enable (wr_enable),
    .exec      (i_exec_if.seq)
  );

  opcode_decoder i_opcode_decoder (
    .ir  (ir),
    .dec (dec)
  );

  // Registers and ALU
  register_file i_register_file (
    .clk    (clk),
    .resetn (resetn),
    .exec   (i_exec_if.regs)
  );

endmodule

`default_nettype wire

// ==== bench/cpu_assertions.sv ====
// Bus sequencer checks
`default_nettype none

module cpu_assertions import cpu_pkg::*; (
  input logic   clk,
  input logic   resetn,
  input state_e state,
  input logic   wr_enable,
  input logic   execute
);

  // Failed assertion count
  int failures = 0;

  // --------------------------------------------------
  // Bus strobes
  // --------------------------------------------------
  write_in_abs2: assert property (
    @(posedge clk) disable iff (!resetn) wr_enable |-> state == ABS_2
  ) else begin
    $error("wr_enable high outside ABS_2");
    failures++;
  end

  // Fetch cycle never ends an instruction
  no_execute_in_fetch: assert property (
    @(posedge clk) disable iff (!resetn) state == FETCH |-> !execute
  ) else begin
    $error("execute pulsed in FETCH");
    failures++;
  end

  // Only reset leaves HALT
  halt_held: assert property (
    @(posedge clk) (state == HALT && resetn) |=> state == HALT
  ) else begin
    $error("HALT left without reset");
    failures++;
  end

endmodule

bind bus_sequencer cpu_assertions i_cpu_assertions (
  .clk       (clk),
  .resetn    (resetn),
  .state     (state),
  .wr_enable (wr_enable),
  .execute   (exec_pulse)
);

`default_nettype wire

// ==== bench/tb_cpu.sv ====
// CPU core testbench
`default_nettype none

module tb_cpu import cpu_pkg::*; ();

  localparam int WAIT_LIMIT  = 400;
  localparam int HOLD_CYCLES = 40;

  logic  clk;
  logic  resetn;
  byte_t rd_data;
  addr_t address;
  byte_t wr_data;
  logic  wr_enable;

  // 64K memory and write records
  byte_t mem [0:65535];
  addr_t seen_addr [$];
  byte_t seen_data [$];
  addr_t exp_addr [$];
  byte_t exp_data [$];
  int    exp_test [$];
  addr_t halt_addr;
  int    checks;
  int    errors;
  bit    timed_out;

  cpu_top i_cpu_top (
    .clk       (clk),
    .resetn    (resetn),
    .rd_data   (rd_data),
    .address   (address),
    .wr_data   (wr_data),
    .wr_enable (wr_enable)
  );

  // --------------------------------------------------
  // Clock, memory model and write monitor
  // --------------------------------------------------
  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Combinational read of the registered address
  assign rd_data = mem[address];

  always @(posedge clk) begin
    if (wr_enable === 1'b1) begin
      mem[address] <= wr_data;
    end
  end

  // Mid-cycle sample of each write cycle
  always @(negedge clk) begin
    if (resetn && wr_enable === 1'b1) begin
      seen_addr.push_back(address);
      seen_data.push_back(wr_data);
    end
  end

  // --------------------------------------------------
  // Compare tasks
  // --------------------------------------------------
  task automatic check_address(input addr_t expected);
    checks++;
    if (address !== expected) begin
      errors++;
      $display("** Error: address = %h, expected %h", address, expected);
    end
  endtask

  task automatic check_strobe(input logic expected);
    checks++;
    if (wr_enable !== expected) begin
      errors++;
      $display("** Error: wr_enable = %h, expected %h", wr_enable, expected);
    end
  endtask

  // Oldest collected write against the next expected one
  task automatic check_write(input addr_t addr, input byte_t data);
    addr_t got_addr;
    byte_t got_data;
    got_addr = seen_addr.pop_front();
    got_data = seen_data.pop_front();
    checks++;
    if (got_addr !== addr || got_data !== data) begin
      errors++;
      $display("** Error: address = %h wr_data = %h, expected %h and %h",
               got_addr, got_data, addr, data);
    end
  endtask

  // --------------------------------------------------
  // Stimulus file
  // --------------------------------------------------
  task automatic load_stimulus();
    int               fd;
    int               n;
    int               count;
    int               tag;
    logic [7:0]       kind;
    addr_t            addr;
    byte_t            data;
    logic [8*128-1:0] rest;
    fd = $fopen("bench/program_stim.txt", "r");
    if (fd == 0) begin
      $display("Stimulus file bench/program_stim.txt could not be opened");
      errors++;
    end else begin
      while ($fscanf(fd, " %c", kind) == 1) begin
        case (kind)
          // Run of consecutive memory bytes
          "M": begin
            n = $fscanf(fd, "%h %d", addr, count);
            repeat (count) begin
              n = $fscanf(fd, "%h", data);
              mem[addr] = data;
              addr++;
            end
          end
          "W": begin
            n = $fscanf(fd, "%h %h %d", addr, data, tag);
            exp_addr.push_back(addr);
            exp_data.push_back(data);
            exp_test.push_back(tag);
          end
          "H": n = $fscanf(fd, "%h", halt_addr);
          "#": n = $fgets(rest, fd);
          default: begin
            $display("Unknown record kind %c in the stimulus file", kind);
            errors++;
            n = $fgets(rest, fd);
          end
        endcase
      end
      $fclose(fd);
    end
  endtask

  // --------------------------------------------------
  // Tests
  // --------------------------------------------------
  function automatic string group_name(input int num);
    case (num)
      2: return "immediate load and store";
      3: return "absolute loads and stores";
      4: return "carry";
      5: return "logic operations";
      default: return "unnamed group";
    endcase
  endfunction

  task automatic print_test_line(input int num, input string name, input int start);
    $display("test %0d, %s: %0d errors", num, name, errors - start);
  endtask

  task automatic wait_for_write(output bit got);
    int n;
    n = 0;
    got = (seen_addr.size() > 0);
    while (!got && n < WAIT_LIMIT) begin
      @(negedge clk);
      #1;
      got = (seen_addr.size() > 0);
      n++;
    end
    if (!got) begin
      $display("Timeout: no memory write within %0d cycles", WAIT_LIMIT);
      errors++;
      timed_out = 1'b1;
    end
  endtask

  task automatic reset_vector_test();
    addr_t vector;
    int    start;
    start  = errors;
    vector = {mem[RESET_VECTOR + 16'd1], mem[RESET_VECTOR]};
    repeat (16) begin
      @(posedge clk);
      #1;
      check_address(RESET_VECTOR);
      check_strobe(1'b0);
    end
    resetn = 1'b1;
    // Vector low, vector high, then first fetch
    @(posedge clk);
    #1;
    check_address(RESET_VECTOR);
    @(posedge clk);
    #1;
    check_address(RESET_VECTOR + 16'd1);
    @(posedge clk);
    #1;
    check_address(vector);
    print_test_line(1, "reset vector", start);
  endtask

  task automatic write_sequence_test();
    int k;
    int start;
    bit got;
    start = errors;
    for (k = 0; k < exp_addr.size() && !timed_out; k++) begin
      wait_for_write(got);
      if (got) begin
        check_write(exp_addr[k], exp_data[k]);
      end
      // Last write of a group ends its test
      if (!got || k + 1 == exp_addr.size() || exp_test[k + 1] != exp_test[k]) begin
        print_test_line(exp_test[k], group_name(exp_test[k]), start);
        start = errors;
      end
    end
  endtask

  task automatic jump_halt_test();
    int n;
    int start;
    bit reached;
    start   = errors;
    reached = 1'b0;
    n       = 0;
    while (!reached && n < WAIT_LIMIT) begin
      @(posedge clk);
      #1;
      reached = (address === halt_addr);
      n++;
    end
    if (reached) begin
      // Parked core, address held and no strobe
      repeat (HOLD_CYCLES) begin
        @(posedge clk);
        #1;
        check_address(halt_addr);
        check_strobe(1'b0);
      end
    end else begin
      $display("Timeout: address never reached the halt address %h", halt_addr);
      errors++;
    end
    if (seen_addr.size() != 0) begin
      $display("Unexpected write to address %h after the expected writes", seen_addr[0]);
      errors++;
    end
    print_test_line(6, "jump and halt", start);
  endtask

  initial begin : main
    int i;
    resetn    = 1'b0;
    checks    = 0;
    errors    = 0;
    timed_out = 1'b0;
    halt_addr = '0;
    // Background fill from both address bytes
    for (i = 0; i < 65536; i++) begin
      mem[i] = byte_t'(i[15:8] ^ i[7:0]);
    end
    load_stimulus();
    reset_vector_test();
    write_sequence_test();
    if (!timed_out) begin
      jump_halt_test();
    end
    errors += i_cpu_top.i_bus_sequencer.i_cpu_assertions.failures;
    $display("%0d checks, %0d errors, %0d assertion failures", checks, errors,
             i_cpu_top.i_bus_sequencer.i_cpu_assertions.failures);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== bench/program_stim.txt ====
# M: start address, byte count (decimal), bytes; W: write address, data, test number
# H: address held after the illegal opcode
M FFFC 2 00 02
M 0200 11 A9 5A 8D 00 03 AD 00 04 AE 01 04
M 020B 12 AC 02 04 8D 01 03 8E 02 03 8C 03 03
M 0217 11 AD 03 04 38 6D 04 04 8D 04 03 18
M 0222 12 6D 05 04 8D 05 03 6D 06 04 8D 06 03
M 022E 10 AD 00 04 2D 07 04 8D 07 03 EA
M 0238 12 0D 08 04 8D 08 03 4D 09 04 8D 09 03
M 0244 6 4C 80 02 8D 0A 03
M 0280 1 02
M 0400 10 3C C3 7E 10 22 F0 01 0F C0 FF
W 0300 5A 2
W 0301 3C 3
W 0302 C3 3
W 0303 7E 3
W 0304 33 4
W 0305 23 4
W 0306 25 4
W 0307 0C 5
W 0308 CC 5
W 0309 33 5
H 0281

// ==== tb.f ====
source/cpu_pkg.sv
source/exec_if.sv
source/opcode_decoder.sv
source/alu.sv
source/register_file.sv
source/bus_sequencer.sv
source/cpu_top.sv
bench/cpu_assertions.sv
bench/tb_cpu.sv

// ==== Bender.yml ====
package:
  name: cpu6502

sources:
  - source/cpu_pkg.sv
  - source/exec_if.sv
  - source/opcode_decoder.sv
  - source/alu.sv
  - source/register_file.sv
  - source/bus_sequencer.sv
  - source/cpu_top.sv
  - target: test
    files:
      - bench/cpu_assertions.sv
      - bench/tb_cpu.sv
